/* hw/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ********************
// register addressing
// ********************

// x0..x31 and f0..f31
`define ISSUE_RADDR_W 5

// ********************
// rounding mode
// ********************

// rm field and frm CSR, 3'b111 selects dynamic
`define ISSUE_RM_W 3

// ********************
// issue width
// ********************

`define ISSUE_LANES 2

`endif

/* hw/issue_pkg.sv */
`include "issue_params.svh"

package issue_pkg;

  typedef enum logic [3:0] {
    op_nop,
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_csr_read,
    op_csr_write,
    op_div,
    op_fload,
    op_fstore,
    op_fpu
  } op_kind_e;

  // one decoded instruction
  typedef struct packed {
    logic                      valid;
    op_kind_e                  op;
    logic [`ISSUE_RADDR_W-1:0] rd;
    logic [`ISSUE_RADDR_W-1:0] rs1;
    logic [`ISSUE_RADDR_W-1:0] rs2;
    logic [`ISSUE_RADDR_W-1:0] rs3;
    logic [`ISSUE_RM_W-1:0]    rm;
    logic                      fp_rs3;
  } issue_slot_t;

  localparam issue_slot_t slot_reset = '{
    valid:  1'b0,
    op:     op_nop,
    rd:     '0,
    rs1:    '0,
    rs2:    '0,
    rs3:    '0,
    rm:     '0,
    fp_rs3: 1'b0
  };

  // integer rs1, fp memory ops use it as base address
  function automatic logic reads_int(input op_kind_e op);
    case (op)
      op_alu, op_load, op_store, op_branch, op_csr_write, op_div, op_fload, op_fstore:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // some source comes from the fp register file
  function automatic logic reads_fp(input op_kind_e op);
    return (op == op_fstore) || (op == op_fpu);
  endfunction

  function automatic logic is_mem(input op_kind_e op);
    return (op == op_load) || (op == op_store) || (op == op_fload) || (op == op_fstore);
  endfunction

endpackage

/* hw/issue_slot_if.sv */
`timescale 1ns/100ps

// one instruction slot on its way to the issue register
interface issue_slot_if;

  issue_pkg::issue_slot_t slot;

  // accumulated hold request for this slot
  logic lane_stall;

  // ********************
  // producer side
  // ********************

  modport src (
    output slot,
    output lane_stall
  );

  // ********************
  // lane and stage side
  // ********************

  // lane takes its slot here, its own hold request goes out on the next hop
  modport lane (
    input slot,
    input lane_stall
  );

  modport sink (
    input slot,
    input lane_stall
  );

endinterface

/* hw/pair_steer.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module pair_steer (
  input  issue_pkg::issue_slot_t in0,
  input  issue_pkg::issue_slot_t in1,
  output logic                   split,
  issue_slot_if.src              lane [`ISSUE_LANES]
);

  issue_pkg::issue_slot_t steer [`ISSUE_LANES];

  logic both_valid;
  logic uses_src;
  logic raw_dep;
  logic mem_pair;
  logic lone_second;

  // ********************
  // pairing checks
  // ********************

  assign both_valid = in0.valid && in1.valid;
  assign lone_second = !in0.valid && in1.valid;

  assign uses_src = issue_pkg::reads_int(in1.op) || issue_pkg::reads_fp(in1.op);

  // conservative: any named source against instr0 destination
  always_comb begin
    raw_dep = 1'b0;
    if (in0.rd != '0 && uses_src) begin
      if (in1.rs1 == in0.rd || in1.rs2 == in0.rd) begin
        raw_dep = 1'b1;
      end
      if (in1.fp_rs3 && in1.rs3 == in0.rd) begin
        raw_dep = 1'b1;
      end
    end
  end

  // single memory port downstream
  assign mem_pair = issue_pkg::is_mem(in0.op) && issue_pkg::is_mem(in1.op);

  // ********************
  // lane assignment
  // ********************

  always_comb begin
    split = 1'b0;
    steer[0] = in0;
    steer[1] = in1;
    if (lone_second) begin
      // move it up so lane 0 always holds the older valid op
      steer[0] = in1;
      steer[1] = issue_pkg::slot_reset;
    end else if (both_valid && (raw_dep || mem_pair)) begin
      steer[1] = issue_pkg::slot_reset;
      split = 1'b1;
    end
  end

  for (genvar i = 0; i < `ISSUE_LANES; i++) begin : g_out
    assign lane[i].slot = steer[i];
  end

endmodule

/* hw/issue_lane.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_lane (
  input  logic                      fs_on,
  input  logic [`ISSUE_RM_W-1:0]    frm,
  input  logic                      ex_load,
  input  logic                      ex_fload,
  input  logic [`ISSUE_RADDR_W-1:0] ex_waddr,
  output logic                      rd_en1,
  output logic                      rd_en2,
  output logic                      rd_en3,
  output logic [`ISSUE_RADDR_W-1:0] rd_addr1,
  output logic [`ISSUE_RADDR_W-1:0] rd_addr2,
  output logic [`ISSUE_RADDR_W-1:0] rd_addr3,
  issue_slot_if.lane                slot_in,
  issue_slot_if.src                 slot_out
);

  issue_pkg::issue_slot_t s;

  logic is_fp_op;
  // port reads the fp register file
  logic fp_port1;
  logic fp_port2;
  logic hit1;
  logic hit2;
  logic hit3;
  logic load_use;

  // ********************
  // fp mask and rm
  // ********************

  assign is_fp_op = (slot_in.slot.op == issue_pkg::op_fload) ||
                    (slot_in.slot.op == issue_pkg::op_fstore) ||
                    (slot_in.slot.op == issue_pkg::op_fpu);

  always_comb begin
    s = slot_in.slot;
    if (!fs_on && is_fp_op) begin
      s.op = issue_pkg::op_nop;
      s.rm = '0;
      s.fp_rs3 = 1'b0;
    end
    // dynamic rounding
    if (s.rm == {`ISSUE_RM_W{1'b1}}) begin
      s.rm = frm;
    end
  end

  // ********************
  // read requests
  // ********************

  always_comb begin
    rd_en1 = s.valid && (issue_pkg::reads_int(s.op) || s.op == issue_pkg::op_fpu);
    rd_en2 = s.valid && (issue_pkg::reads_fp(s.op) ||
                         s.op inside {issue_pkg::op_alu, issue_pkg::op_store,
                                      issue_pkg::op_branch, issue_pkg::op_div});
    rd_en3 = s.valid && s.op == issue_pkg::op_fpu && s.fp_rs3;
    fp_port1 = (s.op == issue_pkg::op_fpu);
    fp_port2 = issue_pkg::reads_fp(s.op);
  end

  assign rd_addr1 = s.rs1;
  assign rd_addr2 = s.rs2;
  assign rd_addr3 = s.rs3;

  // ********************
  // load-use check
  // ********************

  // load class must match the register file of the port
  assign hit1 = rd_en1 && (ex_waddr == s.rs1) && (fp_port1 ? ex_fload : ex_load);
  assign hit2 = rd_en2 && (ex_waddr == s.rs2) && (fp_port2 ? ex_fload : ex_load);
  assign hit3 = rd_en3 && (ex_waddr == s.rs3) && ex_fload;

  assign load_use = (ex_waddr != '0) && (hit1 || hit2 || hit3);

  assign slot_out.slot = s;
  assign slot_out.lane_stall = load_use;

endmodule

/* hw/issue_stage.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   down_stall,
  input  logic                   ex_csr_write,
  input  logic                   mem_csr_write,
  input  logic                   ex_div,
  issue_slot_if.sink             lanes [`ISSUE_LANES],
  output logic                   stall,
  output issue_pkg::issue_slot_t issued [`ISSUE_LANES]
);

  issue_pkg::issue_slot_t lane_slot [`ISSUE_LANES];
  issue_pkg::issue_slot_t issue_d [`ISSUE_LANES];

  logic [`ISSUE_LANES-1:0] lane_stall;
  logic serialize;
  logic hazard;

  // ********************
  // collect lanes
  // ********************

  for (genvar i = 0; i < `ISSUE_LANES; i++) begin : g_lane
    assign lane_slot[i] = lanes[i].slot;
    assign lane_stall[i] = lanes[i].lane_stall;
  end

  // ********************
  // stall merge
  // ********************

  // csr write must retire before anything reads csr state,
  // divider is not pipelined
  assign serialize = ex_csr_write || mem_csr_write || ex_div;

  assign hazard = (|lane_stall) || serialize;

  // flush drops the pair anyway, nothing to hold
  assign stall = !flush && (hazard || down_stall);

  // ********************
  // next issue pair
  // ********************

  always_comb begin
    for (int i = 0; i < `ISSUE_LANES; i++) begin
      if (flush) begin
        issue_d[i] = issue_pkg::slot_reset;
      end else if (down_stall) begin
        // replay what execute has not taken yet
        issue_d[i] = issued[i];
      end else if (hazard) begin
        // bubble
        issue_d[i] = issue_pkg::slot_reset;
      end else begin
        issue_d[i] = lane_slot[i];
      end
    end
  end

  // ********************
  // issue register
  // ********************

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `ISSUE_LANES; i++) begin
        issued[i] <= issue_pkg::slot_reset;
      end
    end else begin
      for (int i = 0; i < `ISSUE_LANES; i++) begin
        issued[i] <= issue_d[i];
      end
    end
  end

endmodule

/* hw/issue_unit_top.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_unit_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      down_stall,
  input  logic                      fs_on,
  input  logic [`ISSUE_RM_W-1:0]    frm,
  input  logic                      ex_load,
  input  logic                      ex_fload,
  input  logic [`ISSUE_RADDR_W-1:0] ex_waddr,
  input  logic                      ex_csr_write,
  input  logic                      mem_csr_write,
  input  logic                      ex_div,
  input  logic                      in0_valid,
  input  issue_pkg::op_kind_e       in0_op,
  input  logic [`ISSUE_RADDR_W-1:0] in0_rd,
  input  logic [`ISSUE_RADDR_W-1:0] in0_rs1,
  input  logic [`ISSUE_RADDR_W-1:0] in0_rs2,
  input  logic [`ISSUE_RADDR_W-1:0] in0_rs3,
  input  logic [`ISSUE_RM_W-1:0]    in0_rm,
  input  logic                      in1_valid,
  input  issue_pkg::op_kind_e       in1_op,
  input  logic [`ISSUE_RADDR_W-1:0] in1_rd,
  input  logic [`ISSUE_RADDR_W-1:0] in1_rs1,
  input  logic [`ISSUE_RADDR_W-1:0] in1_rs2,
  input  logic [`ISSUE_RADDR_W-1:0] in1_rs3,
  input  logic [`ISSUE_RM_W-1:0]    in1_rm,
  output logic                      lane0_rd_en1,
  output logic                      lane0_rd_en2,
  output logic                      lane0_rd_en3,
  output logic [`ISSUE_RADDR_W-1:0] lane0_rd_addr1,
  output logic [`ISSUE_RADDR_W-1:0] lane0_rd_addr2,
  output logic [`ISSUE_RADDR_W-1:0] lane0_rd_addr3,
  output logic                      lane1_rd_en1,
  output logic                      lane1_rd_en2,
  output logic                      lane1_rd_en3,
  output logic [`ISSUE_RADDR_W-1:0] lane1_rd_addr1,
  output logic [`ISSUE_RADDR_W-1:0] lane1_rd_addr2,
  output logic [`ISSUE_RADDR_W-1:0] lane1_rd_addr3,
  output logic                      stall,
  output logic                      split,
  output logic                      iss0_valid,
  output issue_pkg::op_kind_e       iss0_op,
  output logic [`ISSUE_RADDR_W-1:0] iss0_rd,
  output logic [`ISSUE_RADDR_W-1:0] iss0_rs1,
  output logic [`ISSUE_RADDR_W-1:0] iss0_rs2,
  output logic [`ISSUE_RADDR_W-1:0] iss0_rs3,
  output logic [`ISSUE_RM_W-1:0]    iss0_rm,
  output logic                      iss1_valid,
  output issue_pkg::op_kind_e       iss1_op,
  output logic [`ISSUE_RADDR_W-1:0] iss1_rd,
  output logic [`ISSUE_RADDR_W-1:0] iss1_rs1,
  output logic [`ISSUE_RADDR_W-1:0] iss1_rs2,
  output logic [`ISSUE_RADDR_W-1:0] iss1_rs3,
  output logic [`ISSUE_RM_W-1:0]    iss1_rm
);

  issue_pkg::issue_slot_t in0;
  issue_pkg::issue_slot_t in1;
  issue_pkg::issue_slot_t issued [`ISSUE_LANES];

  logic                      steer_split;
  logic                      rd_en1 [`ISSUE_LANES];
  logic                      rd_en2 [`ISSUE_LANES];
  logic                      rd_en3 [`ISSUE_LANES];
  logic [`ISSUE_RADDR_W-1:0] rd_addr1 [`ISSUE_LANES];
  logic [`ISSUE_RADDR_W-1:0] rd_addr2 [`ISSUE_LANES];
  logic [`ISSUE_RADDR_W-1:0] rd_addr3 [`ISSUE_LANES];

  issue_slot_if steer_if [`ISSUE_LANES] ();
  issue_slot_if lane_if [`ISSUE_LANES] ();

  // fpu ops here are the fused kind, all read rs3
  always_comb begin
    in0 = '{valid: in0_valid, op: in0_op, rd: in0_rd, rs1: in0_rs1, rs2: in0_rs2,
            rs3: in0_rs3, rm: in0_rm, fp_rs3: (in0_op == issue_pkg::op_fpu)};
    in1 = '{valid: in1_valid, op: in1_op, rd: in1_rd, rs1: in1_rs1, rs2: in1_rs2,
            rs3: in1_rs3, rm: in1_rm, fp_rs3: (in1_op == issue_pkg::op_fpu)};
  end

  pair_steer u_steer (
    .in0   (in0),
    .in1   (in1),
    .split (steer_split),
    .lane  (steer_if)
  );

  for (genvar i = 0; i < `ISSUE_LANES; i++) begin : g_lane
    issue_lane u_lane (
      .fs_on    (fs_on),
      .frm      (frm),
      .ex_load  (ex_load),
      .ex_fload (ex_fload),
      .ex_waddr (ex_waddr),
      .rd_en1   (rd_en1[i]),
      .rd_en2   (rd_en2[i]),
      .rd_en3   (rd_en3[i]),
      .rd_addr1 (rd_addr1[i]),
      .rd_addr2 (rd_addr2[i]),
      .rd_addr3 (rd_addr3[i]),
      .slot_in  (steer_if[i]),
      .slot_out (lane_if[i])
    );
  end

  issue_stage u_stage (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .down_stall    (down_stall),
    .ex_csr_write  (ex_csr_write),
    .mem_csr_write (mem_csr_write),
    .ex_div        (ex_div),
    .lanes         (lane_if),
    .stall         (stall),
    .issued        (issued)
  );

  // split only counts when instr0 actually went in
  assign split = steer_split && !stall && !flush;

  // ********************
  // flatten to ports
  // ********************

  assign lane0_rd_en1 = rd_en1[0];
  assign lane0_rd_en2 = rd_en2[0];
  assign lane0_rd_en3 = rd_en3[0];
  assign lane0_rd_addr1 = rd_addr1[0];
  assign lane0_rd_addr2 = rd_addr2[0];
  assign lane0_rd_addr3 = rd_addr3[0];
  assign lane1_rd_en1 = rd_en1[1];
  assign lane1_rd_en2 = rd_en2[1];
  assign lane1_rd_en3 = rd_en3[1];
  assign lane1_rd_addr1 = rd_addr1[1];
  assign lane1_rd_addr2 = rd_addr2[1];
  assign lane1_rd_addr3 = rd_addr3[1];

  assign iss0_valid = issued[0].valid;
  assign iss0_op = issued[0].op;
  assign iss0_rd = issued[0].rd;
  assign iss0_rs1 = issued[0].rs1;
  assign iss0_rs2 = issued[0].rs2;
  assign iss0_rs3 = issued[0].rs3;
  assign iss0_rm = issued[0].rm;
  assign iss1_valid = issued[1].valid;
  assign iss1_op = issued[1].op;
  assign iss1_rd = issued[1].rd;
  assign iss1_rs1 = issued[1].rs1;
  assign iss1_rs2 = issued[1].rs2;
  assign iss1_rs3 = issued[1].rs3;
  assign iss1_rm = issued[1].rm;

endmodule

/* test/issue_unit_vectors.svh */
`ifndef ISSUE_UNIT_VECTORS_SVH
`define ISSUE_UNIT_VECTORS_SVH

// ctl: flush down_stall fs_on frm ex_load ex_fload ex_waddr ex_csr_write mem_csr_write ex_div
// in0/in1: valid op rd rs1 rs2 rs3 rm
// exp: stall split, then valid op rm of lane 0 and of lane 1 issued one cycle later
task automatic load_table();
  // ********************
  // pair steering
  // ********************
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{0, 0, 1, c_alu, 3'd0, 1, c_alu, 3'd0});
  // instr1 reads instr0 rd
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd1, 5'd6, 5'd0, 3'd0}, '{0, 1, 1, c_alu, 3'd0, 0, c_nop, 3'd0});
  // two memory ops
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_ld, 5'd2, 5'd3, 5'd0, 5'd0, 3'd0},
          '{1, c_st, 5'd0, 5'd4, 5'd5, 5'd0, 3'd0}, '{0, 1, 1, c_ld, 3'd0, 0, c_nop, 3'd0});
  // x0 is never a dependency
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd0, 5'd1, 5'd0, 5'd0, 3'd0},
          '{1, c_alu, 5'd2, 5'd0, 5'd0, 5'd0, 3'd0}, '{0, 0, 1, c_alu, 3'd0, 1, c_alu, 3'd0});
  // lone second instruction
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{0, c_nop, 5'd0, 5'd0, 5'd0, 5'd0, 3'd0},
          '{1, c_alu, 5'd3, 5'd4, 5'd5, 5'd0, 3'd0}, '{0, 0, 1, c_alu, 3'd0, 0, c_nop, 3'd0});
  // ********************
  // fp mask, rounding
  // ********************
  add_row('{0, 0, 0, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_fpu, 5'd1, 5'd2, 5'd3, 5'd4, 3'd1},
          '{1, c_fld, 5'd5, 5'd6, 5'd0, 5'd0, 3'd0}, '{0, 0, 1, c_nop, 3'd0, 1, c_nop, 3'd0});
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_fpu, 5'd1, 5'd2, 5'd3, 5'd4, 3'd7},
          '{1, c_fpu, 5'd5, 5'd6, 5'd7, 5'd8, 3'd3}, '{0, 0, 1, c_fpu, 3'd2, 1, c_fpu, 3'd3});
  // ********************
  // load-use
  // ********************
  add_row('{0, 0, 1, 3'd2, 1, 0, 5'd9, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd9, 5'd2, 5'd0, 3'd0},
          '{1, c_alu, 5'd3, 5'd4, 5'd5, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  add_row('{0, 0, 1, 3'd2, 1, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd0, 5'd0, 5'd0, 3'd0},
          '{1, c_alu, 5'd2, 5'd0, 5'd0, 5'd0, 3'd0}, '{0, 0, 1, c_alu, 3'd0, 1, c_alu, 3'd0});
  // fp load against an integer source
  add_row('{0, 0, 1, 3'd2, 0, 1, 5'd9, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd9, 5'd2, 5'd0, 3'd0},
          '{1, c_alu, 5'd3, 5'd4, 5'd5, 5'd0, 3'd0}, '{0, 0, 1, c_alu, 3'd0, 1, c_alu, 3'd0});
  add_row('{0, 0, 1, 3'd2, 0, 1, 5'd8, 0, 0, 0}, '{1, c_fpu, 5'd1, 5'd2, 5'd3, 5'd8, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  // ********************
  // serializing
  // ********************
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 1, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 1, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 1}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  // ********************
  // replay and flush
  // ********************
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_br, 5'd0, 5'd1, 5'd2, 5'd0, 3'd0},
          '{1, c_div, 5'd7, 5'd3, 5'd4, 5'd0, 3'd0}, '{0, 0, 1, c_br, 3'd0, 1, c_div, 3'd0});
  add_row('{0, 1, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{1, 0, 1, c_br, 3'd0, 1, c_div, 3'd0});
  add_row('{0, 1, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd1, 5'd6, 5'd0, 3'd0}, '{1, 0, 1, c_br, 3'd0, 1, c_div, 3'd0});
  add_row('{1, 1, 1, 3'd2, 0, 0, 5'd0, 1, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd1, 5'd6, 5'd0, 3'd0}, '{0, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  add_row('{1, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_alu, 5'd1, 5'd2, 5'd3, 5'd0, 3'd0},
          '{1, c_alu, 5'd4, 5'd5, 5'd6, 5'd0, 3'd0}, '{0, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  // csr read has no register sources
  add_row('{0, 0, 1, 3'd2, 0, 0, 5'd0, 0, 0, 0}, '{1, c_csrr, 5'd5, 5'd0, 5'd0, 5'd0, 3'd0},
          '{1, c_csrr, 5'd6, 5'd5, 5'd0, 5'd0, 3'd0}, '{0, 0, 1, c_csrr, 3'd0, 1, c_csrr, 3'd0});
  add_row('{0, 0, 1, 3'd2, 0, 1, 5'd4, 0, 0, 0}, '{1, c_fst, 5'd0, 5'd3, 5'd4, 5'd0, 3'd0},
          '{0, c_nop, 5'd0, 5'd0, 5'd0, 5'd0, 3'd0}, '{1, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
  // idle
  add_row('{0, 0, 1, 3'd0, 0, 0, 5'd0, 0, 0, 0}, '{0, c_nop, 5'd0, 5'd0, 5'd0, 5'd0, 3'd0},
          '{0, c_nop, 5'd0, 5'd0, 5'd0, 5'd0, 3'd0}, '{0, 0, 0, c_nop, 3'd0, 0, c_nop, 3'd0});
endtask

`endif

/* test/issue_unit_tb.sv */
`timescale 1ns/100ps
`include "issue_params.svh"

module issue_unit_tb;

  localparam int random_pairs = 200;

  // opcode encodings, in enum order
  localparam logic [3:0] c_nop = 4'd0;
  localparam logic [3:0] c_alu = 4'd1;
  localparam logic [3:0] c_ld = 4'd2;
  localparam logic [3:0] c_st = 4'd3;
  localparam logic [3:0] c_br = 4'd4;
  localparam logic [3:0] c_csrr = 4'd5;
  localparam logic [3:0] c_csrw = 4'd6;
  localparam logic [3:0] c_div = 4'd7;
  localparam logic [3:0] c_fld = 4'd8;
  localparam logic [3:0] c_fst = 4'd9;
  localparam logic [3:0] c_fpu = 4'd10;

  typedef struct packed {
    logic flush;
    logic down_stall;
    logic fs_on;
    logic [`ISSUE_RM_W-1:0] frm;
    logic ex_load;
    logic ex_fload;
    logic [`ISSUE_RADDR_W-1:0] ex_waddr;
    logic ex_csr_write;
    logic mem_csr_write;
    logic ex_div;
  } ctl_t;

  typedef struct packed {
    logic valid;
    logic [3:0] op;
    logic [`ISSUE_RADDR_W-1:0] rd;
    logic [`ISSUE_RADDR_W-1:0] rs1;
    logic [`ISSUE_RADDR_W-1:0] rs2;
    logic [`ISSUE_RADDR_W-1:0] rs3;
    logic [`ISSUE_RM_W-1:0] rm;
  } ins_t;

  typedef struct packed {
    logic stall;
    logic split;
    logic v0;
    logic [3:0] op0;
    logic [`ISSUE_RM_W-1:0] rm0;
    logic v1;
    logic [3:0] op1;
    logic [`ISSUE_RM_W-1:0] rm1;
  } exp_t;

  // read request of one lane, enables then addresses
  typedef struct packed {
    logic [2:0] en;
    logic [`ISSUE_RADDR_W-1:0] a1;
    logic [`ISSUE_RADDR_W-1:0] a2;
    logic [`ISSUE_RADDR_W-1:0] a3;
  } reads_t;

  typedef struct {
    ctl_t ctl;
    ins_t in0;
    ins_t in1;
    exp_t exp;
  } row_t;

  row_t rows[$];
  integer seed = 83;
  int errors = 0;

  logic clock;
  logic reset;
  logic flush, down_stall, fs_on, ex_load, ex_fload, ex_csr_write, mem_csr_write, ex_div;
  logic [`ISSUE_RM_W-1:0] frm;
  logic [`ISSUE_RADDR_W-1:0] ex_waddr;
  logic in0_valid, in1_valid;
  issue_pkg::op_kind_e in0_op, in1_op;
  logic [`ISSUE_RADDR_W-1:0] in0_rd, in0_rs1, in0_rs2, in0_rs3;
  logic [`ISSUE_RADDR_W-1:0] in1_rd, in1_rs1, in1_rs2, in1_rs3;
  logic [`ISSUE_RM_W-1:0] in0_rm, in1_rm;
  logic lane0_rd_en1, lane0_rd_en2, lane0_rd_en3, lane1_rd_en1, lane1_rd_en2, lane1_rd_en3;
  logic [`ISSUE_RADDR_W-1:0] lane0_rd_addr1, lane0_rd_addr2, lane0_rd_addr3;
  logic [`ISSUE_RADDR_W-1:0] lane1_rd_addr1, lane1_rd_addr2, lane1_rd_addr3;
  logic stall, split;
  logic iss0_valid, iss1_valid;
  issue_pkg::op_kind_e iss0_op, iss1_op;
  logic [`ISSUE_RADDR_W-1:0] iss0_rd, iss0_rs1, iss0_rs2, iss0_rs3;
  logic [`ISSUE_RADDR_W-1:0] iss1_rd, iss1_rs1, iss1_rs2, iss1_rs3;
  logic [`ISSUE_RM_W-1:0] iss0_rm, iss1_rm;

  issue_unit_top uut (.*);

  task automatic add_row(input ctl_t c, input ins_t a, input ins_t b, input exp_t e);
    row_t r;
    r.ctl = c;
    r.in0 = a;
    r.in1 = b;
    r.exp = e;
    rows.push_back(r);
  endtask

  `include "issue_unit_vectors.svh"

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic drive(input ctl_t c, input ins_t a, input ins_t b);
    {flush, down_stall, fs_on, frm, ex_load, ex_fload} <= {c.flush, c.down_stall, c.fs_on,
                                                          c.frm, c.ex_load, c.ex_fload};
    {ex_waddr, ex_csr_write, mem_csr_write, ex_div} <= {c.ex_waddr, c.ex_csr_write,
                                                        c.mem_csr_write, c.ex_div};
    {in0_valid, in0_rd, in0_rs1, in0_rs2, in0_rs3, in0_rm} <= {a.valid, a.rd, a.rs1, a.rs2,
                                                               a.rs3, a.rm};
    {in1_valid, in1_rd, in1_rs1, in1_rs2, in1_rs3, in1_rm} <= {b.valid, b.rd, b.rs1, b.rs2,
                                                               b.rs3, b.rm};
    in0_op <= issue_pkg::op_kind_e'(a.op);
    in1_op <= issue_pkg::op_kind_e'(b.op);
  endtask

  task automatic check_issued(input exp_t e, input string tag);
    compare(iss0_valid, e.v0, {tag, " iss0_valid"});
    compare(iss0_op, e.op0, {tag, " iss0_op"});
    compare(iss0_rm, e.rm0, {tag, " iss0_rm"});
    compare(iss1_valid, e.v1, {tag, " iss1_valid"});
    compare(iss1_op, e.op1, {tag, " iss1_op"});
    compare(iss1_rm, e.rm1, {tag, " iss1_rm"});
  endtask

  // every field of both issued slots
  task automatic check_slots(input ins_t s0, input ins_t s1, input string tag);
    compare({iss0_valid, iss0_op, iss0_rd, iss0_rs1, iss0_rs2, iss0_rs3, iss0_rm}, s0,
            {tag, " lane 0 issued"});
    compare({iss1_valid, iss1_op, iss1_rd, iss1_rs1, iss1_rs2, iss1_rs3, iss1_rm}, s1,
            {tag, " lane 1 issued"});
  endtask

  // ********************
  // reference model
  // ********************

  // fp mask, dynamic rm, then the load-use test of one lane
  task automatic lane_model(input ctl_t c, input ins_t s, output ins_t o, output logic hold,
                            output reads_t r);
    logic en1, en2, en3, fp1, fp2;
    o = s;
    if (!c.fs_on && (s.op == c_fld || s.op == c_fst || s.op == c_fpu)) begin
      o.op = c_nop;
      o.rm = '0;
    end
    if (o.rm == 3'd7) o.rm = c.frm;
    en1 = o.valid && (o.op inside {c_alu, c_ld, c_st, c_br, c_csrw, c_div, c_fld, c_fst, c_fpu});
    en2 = o.valid && (o.op inside {c_alu, c_st, c_br, c_div, c_fst, c_fpu});
    en3 = o.valid && o.op == c_fpu;
    fp1 = o.op == c_fpu;
    fp2 = o.op == c_fst || o.op == c_fpu;
    hold = (c.ex_waddr != 0) &&
           ((en1 && o.rs1 == c.ex_waddr && (fp1 ? c.ex_fload : c.ex_load)) ||
            (en2 && o.rs2 == c.ex_waddr && (fp2 ? c.ex_fload : c.ex_load)) ||
            (en3 && o.rs3 == c.ex_waddr && c.ex_fload));
    r.en = {en1, en2, en3};
    r.a1 = o.rs1;
    r.a2 = o.rs2;
    r.a3 = o.rs3;
  endtask

  // steering, both lanes and the issue register for one cycle
  task automatic predict(input ctl_t c, input ins_t a, input ins_t b, inout ins_t q0,
                         inout ins_t q1, output logic st, output logic sp,
                         output reads_t r0, output reads_t r1);
    ins_t l0, l1, o0, o1;
    logic dep, raw, h0, h1, hazard;
    l0 = a;
    l1 = b;
    raw = 1'b0;
    dep = a.rd != 0 && b.op != c_nop && b.op != c_csrr &&
          (b.rs1 == a.rd || b.rs2 == a.rd || (b.op == c_fpu && b.rs3 == a.rd));
    if (!a.valid && b.valid) begin
      l0 = b;
      l1 = '0;
    end else if (a.valid && b.valid && (dep || (a.op inside {c_ld, c_st, c_fld, c_fst} &&
                                                b.op inside {c_ld, c_st, c_fld, c_fst}))) begin
      l1 = '0;
      raw = 1'b1;
    end
    lane_model(c, l0, o0, h0, r0);
    lane_model(c, l1, o1, h1, r1);
    hazard = h0 || h1 || c.ex_csr_write || c.mem_csr_write || c.ex_div;
    st = !c.flush && (hazard || c.down_stall);
    sp = raw && !st && !c.flush;
    if (c.flush || (!c.down_stall && hazard)) begin
      q0 = '0;
      q1 = '0;
    end else if (!c.down_stall) begin
      q0 = o0;
      q1 = o1;
    end
  endtask

  function automatic ins_t random_ins();
    ins_t s;
    s.valid = ($random(seed) & 3) != 0;
    s.op = {$random(seed)} % 11;
    s.rd = {$random(seed)} % 4;
    s.rs1 = {$random(seed)} % 4;
    s.rs2 = {$random(seed)} % 4;
    s.rs3 = {$random(seed)} % 4;
    s.rm = $random(seed);
    return s;
  endfunction

  function automatic ctl_t random_ctl();
    ctl_t c;
    c.flush = ({$random(seed)} % 16) == 0;
    c.down_stall = ({$random(seed)} % 8) == 0;
    c.fs_on = ({$random(seed)} % 4) != 0;
    c.frm = $random(seed);
    c.ex_load = ({$random(seed)} % 4) == 0;
    c.ex_fload = ({$random(seed)} % 4) == 0;
    c.ex_waddr = {$random(seed)} % 4;
    c.ex_csr_write = ({$random(seed)} % 16) == 0;
    c.mem_csr_write = ({$random(seed)} % 16) == 0;
    c.ex_div = ({$random(seed)} % 16) == 0;
    return c;
  endfunction

  // ********************
  // main sequence
  // ********************

  initial begin
    ctl_t c;
    ins_t a, b, q0, q1;
    reads_t r0, r1;
    logic st, sp;
    reset <= 1'b0;
    drive('{0, 0, 1, 3'd0, 0, 0, 5'd0, 0, 0, 0}, '0, '0);
    load_table();
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    compare(stall, 0, "stall after reset");
    compare(split, 0, "split after reset");
    compare(iss0_valid, 0, "iss0_valid after reset");
    compare(iss1_valid, 0, "iss1_valid after reset");
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clock);
      drive(rows[i].ctl, rows[i].in0, rows[i].in1);
      @(negedge clock);
      compare(stall, rows[i].exp.stall, $sformatf("row %0d stall", i));
      compare(split, rows[i].exp.split, $sformatf("row %0d split", i));
      if (i > 0) check_issued(rows[i-1].exp, $sformatf("row %0d", i - 1));
    end
    @(posedge clock);
    @(negedge clock);
    check_issued(rows[rows.size()-1].exp, "last row");
    // last row is idle, so the register now holds empty slots
    q0 = '0;
    q1 = '0;
    for (int k = 0; k < random_pairs; k++) begin
      c = random_ctl();
      a = random_ins();
      b = random_ins();
      @(posedge clock);
      drive(c, a, b);
      @(negedge clock);
      check_slots(q0, q1, $sformatf("random %0d", k));
      predict(c, a, b, q0, q1, st, sp, r0, r1);
      compare(stall, st, $sformatf("random %0d stall", k));
      compare(split, sp, $sformatf("random %0d split", k));
      compare({lane0_rd_en1, lane0_rd_en2, lane0_rd_en3, lane0_rd_addr1, lane0_rd_addr2,
               lane0_rd_addr3}, r0, $sformatf("random %0d lane 0 reads", k));
      compare({lane1_rd_en1, lane1_rd_en2, lane1_rd_en3, lane1_rd_addr1, lane1_rd_addr2,
               lane1_rd_addr3}, r1, $sformatf("random %0d lane 1 reads", k));
    end
    @(posedge clock);
    @(negedge clock);
    check_slots(q0, q1, "random last");
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #1;
    #((rows.size() + random_pairs + 40) * 20);
    $display("watchdog expired, the simulation timed out before the tests ended");
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
+incdir+test
hw/issue_pkg.sv
hw/issue_slot_if.sv
hw/pair_steer.sv
hw/issue_lane.sv
hw/issue_stage.sv
hw/issue_unit_top.sv
test/issue_unit_tb.sv
